/* rtl/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [2:0]  br_op_t;

	// alu operation codes
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_SLL = 4'd2;
	localparam alu_op_t ALU_SRL = 4'd3;
	localparam alu_op_t ALU_SLT = 4'd4;
	localparam alu_op_t ALU_XOR = 4'd5;
	localparam alu_op_t ALU_OR  = 4'd6;
	localparam alu_op_t ALU_AND = 4'd7;
	// passes operand b straight through
	localparam alu_op_t ALU_LUI = 4'd8;

	localparam br_op_t BR_NONE = 3'd0;
	localparam br_op_t BR_EQ   = 3'd1;
	localparam br_op_t BR_NE   = 3'd2;
	localparam br_op_t BR_LT   = 3'd3;
	localparam br_op_t BR_JAL  = 3'd4;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam word_t INST_EBREAK = 32'h0010_0073;

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_HOLD, FETCH_WAIT} fetch_state_e;

endpackage

/* rtl/rv_issue_if.sv */
`timescale 1ns/1ps
interface issue_if import rv_pkg::*; ();

	logic      valid;
	alu_op_t   alu_op;
	br_op_t    br_op;
	word_t     op_a;
	word_t     op_b;
	word_t     imm;
	word_t     pc;
	reg_addr_t rd;
	logic      rd_write;
	logic      halt;

	// decode side
	modport src (output valid, alu_op, br_op, op_a, op_b, imm, pc, rd, rd_write, halt);

	// alu and branch unit side
	modport dst (input valid, alu_op, br_op, op_a, op_b, imm, pc, rd, rd_write, halt);

endinterface

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
module rv_fetch import rv_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic  clk,
	input  logic  rst_i,
	output word_t imem_addr_o,
	input  word_t imem_data_i,
	input  logic  redirect_valid_i,
	input  word_t redirect_pc_i,
	input  logic  halt_i,
	input  logic  dec_ready_i,
	output logic  inst_valid_o,
	output word_t inst_o,
	output word_t inst_pc_o
);

	fetch_state_e state_q;
	word_t        pc_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= FETCH_IDLE;
			pc_q    <= RESET_PC;
		end else begin
			case (state_q)
				FETCH_IDLE: if (!halt_i) state_q <= FETCH_HOLD;
				FETCH_HOLD: if (dec_ready_i) state_q <= FETCH_WAIT;
				// next pc only ever comes from writeback
				FETCH_WAIT: begin
					if (redirect_valid_i && !halt_i) begin
						pc_q    <= redirect_pc_i;
						state_q <= FETCH_IDLE;
					end
				end
				default: state_q <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == FETCH_IDLE && !halt_i)
			inst_o <= imem_data_i;
	end

	assign imem_addr_o  = pc_q;
	// pc is stable from capture until the redirect
	assign inst_pc_o    = pc_q;
	assign inst_valid_o = (state_q == FETCH_HOLD);

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
module rv_regfile import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i
);

	word_t regs_q [32];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++)
				regs_q[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// x0 is hardwired
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
module rv_decode import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      inst_valid_i,
	input  word_t     inst_i,
	input  word_t     inst_pc_i,
	output logic      dec_ready_o,
	output reg_addr_t rf_raddr1_o,
	output reg_addr_t rf_raddr2_o,
	input  word_t     rf_rdata1_i,
	input  word_t     rf_rdata2_i,
	input  logic      retire_i,
	issue_if.src      issue
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i_type, imm_u_type, imm_b_type, imm_j_type;
	alu_op_t    alu_op_d;
	br_op_t     br_op_d;
	word_t      op_b_d;
	word_t      imm_d;
	logic       rd_write_d;
	logic       halt_d;
	logic       accept;

	assign opcode      = inst_i[6:0];
	assign funct3      = inst_i[14:12];
	assign funct7      = inst_i[31:25];
	assign rf_raddr1_o = inst_i[19:15];
	assign rf_raddr2_o = inst_i[24:20];

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		// anything not matched below is illegal: halt, no write, alu result 0
		alu_op_d   = ALU_LUI;
		br_op_d    = BR_NONE;
		op_b_d     = '0;
		imm_d      = '0;
		rd_write_d = 1'b0;
		halt_d     = 1'b1;
		case (opcode)
			OPC_LUI: begin
				alu_op_d   = ALU_LUI;
				op_b_d     = imm_u_type;
				imm_d      = imm_u_type;
				rd_write_d = 1'b1;
				halt_d     = 1'b0;
			end
			OPC_OPIMM: begin
				op_b_d = imm_i_type;
				imm_d  = imm_i_type;
				case (funct3)
					3'b000: alu_op_d = ALU_ADD;
					3'b010: alu_op_d = ALU_SLT;
					3'b100: alu_op_d = ALU_XOR;
					3'b110: alu_op_d = ALU_OR;
					3'b111: alu_op_d = ALU_AND;
					default: alu_op_d = ALU_LUI;
				endcase
				rd_write_d = (alu_op_d != ALU_LUI);
				halt_d     = (alu_op_d == ALU_LUI);
				if (halt_d)
					op_b_d = '0;
			end
			OPC_OP: begin
				op_b_d = rf_rdata2_i;
				case ({funct7, funct3})
					10'b0000000_000: alu_op_d = ALU_ADD;
					10'b0100000_000: alu_op_d = ALU_SUB;
					10'b0000000_001: alu_op_d = ALU_SLL;
					10'b0000000_101: alu_op_d = ALU_SRL;
					10'b0000000_010: alu_op_d = ALU_SLT;
					10'b0000000_100: alu_op_d = ALU_XOR;
					10'b0000000_110: alu_op_d = ALU_OR;
					10'b0000000_111: alu_op_d = ALU_AND;
					default: alu_op_d = ALU_LUI;
				endcase
				rd_write_d = (alu_op_d != ALU_LUI);
				halt_d     = (alu_op_d == ALU_LUI);
				if (halt_d)
					op_b_d = '0;
			end
			OPC_BRANCH: begin
				// branch unit compares op_a against rs2 carried in op_b
				op_b_d = rf_rdata2_i;
				imm_d  = imm_b_type;
				case (funct3)
					3'b000: br_op_d = BR_EQ;
					3'b001: br_op_d = BR_NE;
					3'b100: br_op_d = BR_LT;
					default: br_op_d = BR_NONE;
				endcase
				halt_d = (br_op_d == BR_NONE);
				if (halt_d)
					op_b_d = '0;
			end
			OPC_JAL: begin
				br_op_d    = BR_JAL;
				imm_d      = imm_j_type;
				rd_write_d = 1'b1;
				halt_d     = 1'b0;
			end
			OPC_SYSTEM: begin
				// ebreak retires with alu result 1 so writeback can tell it apart
				if (inst_i == INST_EBREAK)
					op_b_d = 32'd1;
			end
			default: ;
		endcase
	end

	assign accept = inst_valid_i && dec_ready_o;

	// one instruction in flight
	always_ff @(posedge clk) begin
		if (rst_i) begin
			dec_ready_o <= 1'b1;
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= accept;
			if (accept)
				dec_ready_o <= 1'b0;
			else if (retire_i)
				dec_ready_o <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			issue.alu_op   <= alu_op_d;
			issue.br_op    <= br_op_d;
			issue.op_a     <= rf_rdata1_i;
			issue.op_b     <= op_b_d;
			issue.imm      <= imm_d;
			issue.pc       <= inst_pc_i;
			issue.rd       <= inst_i[11:7];
			issue.rd_write <= rd_write_d;
			issue.halt     <= halt_d;
		end
	end

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
module rv_alu import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	issue_if.dst      issue,
	output logic      alu_valid_o,
	output word_t     alu_result_o,
	output reg_addr_t alu_rd_o,
	output logic      alu_rd_write_o,
	output logic      alu_halt_o
);

	word_t result_d;

	always_comb begin
		case (issue.alu_op)
			ALU_ADD: result_d = issue.op_a + issue.op_b;
			ALU_SUB: result_d = issue.op_a - issue.op_b;
			// only the low five bits give the shift amount
			ALU_SLL: result_d = issue.op_a << issue.op_b[4:0];
			ALU_SRL: result_d = issue.op_a >> issue.op_b[4:0];
			ALU_SLT: result_d = {31'b0, $signed(issue.op_a) < $signed(issue.op_b)};
			ALU_XOR: result_d = issue.op_a ^ issue.op_b;
			ALU_OR:  result_d = issue.op_a | issue.op_b;
			ALU_AND: result_d = issue.op_a & issue.op_b;
			ALU_LUI: result_d = issue.op_b;
			default: result_d = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			alu_valid_o <= 1'b0;
		else
			alu_valid_o <= issue.valid;
	end

	always_ff @(posedge clk) begin
		if (issue.valid) begin
			alu_result_o   <= result_d;
			alu_rd_o       <= issue.rd;
			alu_rd_write_o <= issue.rd_write;
			alu_halt_o     <= issue.halt;
		end
	end

endmodule

/* rtl/rv_branch.sv */
`timescale 1ns/1ps
module rv_branch import rv_pkg::*; (
	input  logic  clk,
	input  logic  rst_i,
	issue_if.dst  issue,
	output logic  br_valid_o,
	output logic  br_taken_o,
	output word_t br_target_o,
	output word_t br_link_o,
	output logic  br_is_jal_o
);

	logic taken_d;

	always_comb begin
		case (issue.br_op)
			BR_EQ:   taken_d = (issue.op_a == issue.op_b);
			BR_NE:   taken_d = (issue.op_a != issue.op_b);
			BR_LT:   taken_d = ($signed(issue.op_a) < $signed(issue.op_b));
			BR_JAL:  taken_d = 1'b1;
			default: taken_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			br_valid_o <= 1'b0;
		else
			br_valid_o <= issue.valid;
	end

	// link doubles as the fall-through pc
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			br_taken_o  <= taken_d;
			br_target_o <= issue.pc + issue.imm;
			br_link_o   <= issue.pc + 32'd4;
			br_is_jal_o <= (issue.br_op == BR_JAL);
		end
	end

endmodule

/* rtl/rv_writeback.sv */
`timescale 1ns/1ps
module rv_writeback import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      alu_valid_i,
	input  word_t     alu_result_i,
	input  reg_addr_t alu_rd_i,
	input  logic      alu_rd_write_i,
	input  logic      alu_halt_i,
	input  logic      br_valid_i,
	input  logic      br_taken_i,
	input  word_t     br_target_i,
	input  word_t     br_link_i,
	input  logic      br_is_jal_i,
	output logic      rf_we_o,
	output reg_addr_t rf_waddr_o,
	output word_t     rf_wdata_o,
	output logic      redirect_valid_o,
	output word_t     redirect_pc_o,
	output logic      retire_valid_o,
	output word_t     retire_pc_o,
	output reg_addr_t retire_rd_o,
	output word_t     retire_wdata_o,
	output logic      finish_o,
	output logic      invalid_o
);

	logic  wb_valid;
	logic  wr_en;
	word_t wr_data;
	logic  is_ebreak;
	logic  is_illegal;

	// both units always deliver on the same edge
	assign wb_valid = alu_valid_i & br_valid_i;
	// a write to x0 counts as no write
	assign wr_en    = alu_rd_write_i && (alu_rd_i != '0);
	assign wr_data  = br_is_jal_i ? br_link_i : alu_result_i;

	assign is_ebreak  = alu_halt_i & alu_result_i[0];
	assign is_illegal = alu_halt_i & ~alu_rd_write_i & ~br_taken_i & ~alu_result_i[0];

	assign rf_we_o    = wb_valid & wr_en;
	assign rf_waddr_o = alu_rd_i;
	assign rf_wdata_o = wr_data;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			retire_valid_o   <= 1'b0;
			redirect_valid_o <= 1'b0;
			finish_o         <= 1'b0;
			invalid_o        <= 1'b0;
		end else begin
			retire_valid_o   <= wb_valid;
			redirect_valid_o <= wb_valid & ~alu_halt_i;
			// both flags are sticky until reset
			if (wb_valid && is_ebreak)
				finish_o <= 1'b1;
			if (wb_valid && is_illegal)
				invalid_o <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_valid) begin
			redirect_pc_o  <= br_taken_i ? br_target_i : br_link_i;
			retire_pc_o    <= br_link_i - 32'd4;
			retire_rd_o    <= wr_en ? alu_rd_i : '0;
			retire_wdata_o <= wr_en ? wr_data : '0;
		end
	end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps
module rv_core import rv_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic      clk,
	input  logic      rst_i,
	output word_t     imem_addr_o,
	input  word_t     imem_data_i,
	output logic      retire_valid_o,
	output word_t     retire_pc_o,
	output reg_addr_t retire_rd_o,
	output word_t     retire_wdata_o,
	output logic      finish_o,
	output logic      invalid_o
);

	// fetch to decode
	logic      inst_valid, dec_ready;
	word_t     inst, inst_pc;
	// register file ports
	reg_addr_t rf_raddr1, rf_raddr2, rf_waddr;
	word_t     rf_rdata1, rf_rdata2, rf_wdata;
	logic      rf_we;
	// execute to writeback
	logic      alu_valid, alu_rd_write, alu_halt;
	word_t     alu_result;
	reg_addr_t alu_rd;
	logic      br_valid, br_taken, br_is_jal;
	word_t     br_target, br_link;
	// writeback to fetch
	logic      redirect_valid;
	word_t     redirect_pc;

	issue_if issue ();

	rv_fetch #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk              (clk),
		.rst_i            (rst_i),
		.imem_addr_o      (imem_addr_o),
		.imem_data_i      (imem_data_i),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.halt_i           (finish_o | invalid_o),
		.dec_ready_i      (dec_ready),
		.inst_valid_o     (inst_valid),
		.inst_o           (inst),
		.inst_pc_o        (inst_pc)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst_i    (rst_i),
		.raddr1_i (rf_raddr1),
		.raddr2_i (rf_raddr2),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata)
	);

	rv_decode u_decode (
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid),
		.inst_i       (inst),
		.inst_pc_i    (inst_pc),
		.dec_ready_o  (dec_ready),
		.rf_raddr1_o  (rf_raddr1),
		.rf_raddr2_o  (rf_raddr2),
		.rf_rdata1_i  (rf_rdata1),
		.rf_rdata2_i  (rf_rdata2),
		.retire_i     (retire_valid_o),
		.issue        (issue.src)
	);

	rv_alu u_alu (
		.clk            (clk),
		.rst_i          (rst_i),
		.issue          (issue.dst),
		.alu_valid_o    (alu_valid),
		.alu_result_o   (alu_result),
		.alu_rd_o       (alu_rd),
		.alu_rd_write_o (alu_rd_write),
		.alu_halt_o     (alu_halt)
	);

	rv_branch u_branch (
		.clk         (clk),
		.rst_i       (rst_i),
		.issue       (issue.dst),
		.br_valid_o  (br_valid),
		.br_taken_o  (br_taken),
		.br_target_o (br_target),
		.br_link_o   (br_link),
		.br_is_jal_o (br_is_jal)
	);

	rv_writeback u_writeback (
		.clk              (clk),
		.rst_i            (rst_i),
		.alu_valid_i      (alu_valid),
		.alu_result_i     (alu_result),
		.alu_rd_i         (alu_rd),
		.alu_rd_write_i   (alu_rd_write),
		.alu_halt_i       (alu_halt),
		.br_valid_i       (br_valid),
		.br_taken_i       (br_taken),
		.br_target_i      (br_target),
		.br_link_i        (br_link),
		.br_is_jal_i      (br_is_jal),
		.rf_we_o          (rf_we),
		.rf_waddr_o       (rf_waddr),
		.rf_wdata_o       (rf_wdata),
		.redirect_valid_o (redirect_valid),
		.redirect_pc_o    (redirect_pc),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_wdata_o   (retire_wdata_o),
		.finish_o         (finish_o),
		.invalid_o        (invalid_o)
	);

endmodule

/* bench/rv_core_properties.sv */
`timescale 1ns/1ps
module rv_core_properties (
	input logic clk,
	input logic rst_i,
	input logic retire_valid_i,
	input logic finish_i,
	input logic invalid_i
);

	// one instruction in flight, so retire is a single pulse
	retire_pulse: assert property (@(posedge clk) disable iff (rst_i)
		retire_valid_i |=> !retire_valid_i)
		else $error("retire_valid_o stayed high for more than one cycle");

	flags_exclusive: assert property (@(posedge clk) disable iff (rst_i)
		!(finish_i && invalid_i))
		else $error("finish_o and invalid_o high together");

	finish_sticky: assert property (@(posedge clk) disable iff (rst_i)
		finish_i |=> finish_i)
		else $error("finish_o dropped before reset");

	invalid_sticky: assert property (@(posedge clk) disable iff (rst_i)
		invalid_i |=> invalid_i)
		else $error("invalid_o dropped before reset");

endmodule

bind rv_core rv_core_properties props (
	.clk            (clk),
	.rst_i          (rst_i),
	.retire_valid_i (retire_valid_o),
	.finish_i       (finish_o),
	.invalid_i      (invalid_o)
);

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
module rv_core_tb;

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 5;
	localparam int PROG_WORDS      = 64;
	localparam int EBREAK_WORD     = 60;
	localparam int RETIRE_INTERVAL = 5;
	// capture, accept, execute and writeback edges after release
	localparam int FIRST_RETIRE    = 4;
	localparam int QUIET_CYCLES    = 3 * RETIRE_INTERVAL;
	localparam int RUN_CYCLES      = RESET_CYCLES + PROG_WORDS * RETIRE_INTERVAL + QUIET_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 50;

	typedef enum {
		K_LUI, K_ADDI, K_SLTI, K_XORI, K_ORI, K_ANDI,
		K_ADD, K_SUB, K_SLL, K_SRL, K_SLT, K_AND, K_OR, K_XOR,
		K_BEQ, K_BNE, K_BLT, K_JAL, K_EBREAK, K_ILLEGAL
	} kind_e;

	logic        clk = 1'b0;
	logic        rst_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_data_i;
	logic        retire_valid_o;
	logic [31:0] retire_pc_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_wdata_o;
	logic        finish_o;
	logic        invalid_o;

	int          seed = 47;
	kind_e       prog_kind [PROG_WORDS];
	logic [4:0]  prog_rd   [PROG_WORDS];
	logic [4:0]  prog_rs1  [PROG_WORDS];
	logic [4:0]  prog_rs2  [PROG_WORDS];
	logic [31:0] prog_imm  [PROG_WORDS];
	logic [31:0] prog_word [PROG_WORDS];
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;

	rv_core #(
		.RESET_PC (32'h0000_0000)
	) i_dut (
		.clk            (clk),
		.rst_i          (rst_i),
		.imem_addr_o    (imem_addr_o),
		.imem_data_i    (imem_data_i),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o    (retire_pc_o),
		.retire_rd_o    (retire_rd_o),
		.retire_wdata_o (retire_wdata_o),
		.finish_o       (finish_o),
		.invalid_o      (invalid_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// word addressed instruction memory
	always @(negedge clk) begin
		imem_data_i <= prog_word[imem_addr_o[7:2]];
	end

	function automatic logic [31:0] encode_inst(kind_e kind, logic [4:0] rd, logic [4:0] rs1,
			logic [4:0] rs2, logic [31:0] imm);
		logic [31:0] word;
		case (kind)
			K_LUI:  word = {imm[31:12], rd, 7'b0110111};
			K_ADDI: word = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
			K_SLTI: word = {imm[11:0], rs1, 3'b010, rd, 7'b0010011};
			K_XORI: word = {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
			K_ORI:  word = {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
			K_ANDI: word = {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
			K_ADD:  word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			K_SUB:  word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			K_SLL:  word = {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
			K_SRL:  word = {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
			K_SLT:  word = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
			K_AND:  word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			K_OR:   word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			K_XOR:  word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			K_BEQ:  word = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
			K_BNE:  word = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
			K_BLT:  word = {imm[12], imm[10:5], rs2, rs1, 3'b100, imm[4:1], imm[11], 7'b1100011};
			K_JAL:  word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
			// opcode 7'h7f is not part of rv32i
			K_ILLEGAL: word = 32'hffff_ffff;
			default: word = 32'h0010_0073;
		endcase
		return word;
	endfunction

	task automatic set_word(int idx, kind_e kind, logic [4:0] rd, logic [4:0] rs1,
			logic [4:0] rs2, logic [31:0] imm);
		prog_kind[idx] = kind;
		prog_rd[idx]   = rd;
		prog_rs1[idx]  = rs1;
		prog_rs2[idx]  = rs2;
		prog_imm[idx]  = imm;
		prog_word[idx] = encode_inst(kind, rd, rs1, rs2, imm);
	endtask

	task automatic build_random_program();
		logic [31:0] r;
		logic [31:0] imm;
		kind_e       kind;
		for (int i = 0; i < PROG_WORDS; i++) begin
			r = $random(seed);
			kind = (i < EBREAK_WORD) ? kind_e'(r % 32'd18) : K_EBREAK;
			imm = $random(seed);
			if (kind == K_LUI)
				imm = {imm[31:12], 12'b0};
			else if (kind == K_BEQ || kind == K_BNE || kind == K_BLT || kind == K_JAL)
				// forward offsets of one to three words
				imm = ((imm % 32'd3) + 32'd1) << 2;
			else
				imm = {{20{imm[11]}}, imm[11:0]};
			// small register window so results get reused
			set_word(i, kind, {2'b0, r[10:8]}, {2'b0, r[13:11]}, {2'b0, r[16:14]}, imm);
		end
	endtask

	task automatic build_illegal_program();
		for (int i = 0; i < PROG_WORDS; i++)
			set_word(i, K_EBREAK, 5'd0, 5'd0, 5'd0, 32'h0);
		set_word(0, K_ADDI, 5'd1, 5'd0, 5'd0, 32'h0000_0123);
		set_word(1, K_ADD, 5'd2, 5'd1, 5'd1, 32'h0);
		set_word(2, K_ILLEGAL, 5'd0, 5'd0, 5'd0, 32'h0);
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s got 0x%h expected 0x%h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic reset_core();
		@(negedge clk);
		rst_i = 1'b1;
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'h0;
		model_pc = 32'h0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_i = 1'b0;
	endtask

	// reference model executes one instruction per retire
	task automatic retire_model(output logic halted);
		logic [5:0]  idx;
		logic [31:0] a, b, imm, val, next_pc;
		logic        wr;
		kind_e       kind;
		idx = model_pc[7:2];
		kind = prog_kind[idx];
		a = model_regs[prog_rs1[idx]];
		b = model_regs[prog_rs2[idx]];
		imm = prog_imm[idx];
		val = 32'h0;
		wr = 1'b1;
		next_pc = model_pc + 32'd4;
		case (kind)
			K_LUI:  val = imm;
			K_ADDI: val = a + imm;
			K_SLTI: val = {31'b0, $signed(a) < $signed(imm)};
			K_XORI: val = a ^ imm;
			K_ORI:  val = a | imm;
			K_ANDI: val = a & imm;
			K_ADD:  val = a + b;
			K_SUB:  val = a - b;
			K_SLL:  val = a << b[4:0];
			K_SRL:  val = a >> b[4:0];
			K_SLT:  val = {31'b0, $signed(a) < $signed(b)};
			K_AND:  val = a & b;
			K_OR:   val = a | b;
			K_XOR:  val = a ^ b;
			K_JAL: begin
				val = model_pc + 32'd4;
				next_pc = model_pc + imm;
			end
			default: begin
				wr = 1'b0;
				if ((kind == K_BEQ && a == b) || (kind == K_BNE && a != b) ||
						(kind == K_BLT && $signed(a) < $signed(b)))
					next_pc = model_pc + imm;
			end
		endcase
		// x0 writes retire as no write
		if (prog_rd[idx] == 5'd0)
			wr = 1'b0;
		check_value("retire_pc_o", retire_pc_o, model_pc);
		// fetch keeps the retiring pc on the bus until the redirect edge
		check_value("imem_addr_o", imem_addr_o, model_pc);
		check_value("retire_rd_o", 32'(retire_rd_o), wr ? 32'(prog_rd[idx]) : 32'h0);
		check_value("retire_wdata_o", retire_wdata_o, wr ? val : 32'h0);
		check_value("finish_o", 32'(finish_o), 32'(kind == K_EBREAK));
		check_value("invalid_o", 32'(invalid_o), 32'(kind == K_ILLEGAL));
		if (wr)
			model_regs[prog_rd[idx]] = val;
		model_pc = next_pc;
		halted = (kind == K_EBREAK || kind == K_ILLEGAL);
	endtask

	task automatic check_halted(logic expect_invalid);
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (retire_valid_o) begin
				$display("an instruction retired after the core halted");
				$display("Simulation failed");
				$fatal(1);
			end
			check_value("finish_o", 32'(finish_o), 32'(!expect_invalid));
			check_value("invalid_o", 32'(invalid_o), 32'(expect_invalid));
		end
	endtask

	task automatic run_program(logic expect_invalid);
		int   cycles;
		int   last;
		logic first;
		logic halted;
		cycles = 0;
		last = 0;
		first = 1'b1;
		halted = 1'b0;
		while (!halted) begin
			@(negedge clk);
			cycles++;
			if (retire_valid_o) begin
				if (first)
					check_value("first retire cycle", cycles, FIRST_RETIRE);
				else
					check_value("retire interval", cycles - last, RETIRE_INTERVAL);
				first = 1'b0;
				last = cycles;
				retire_model(halted);
			end
		end
		check_halted(expect_invalid);
	endtask

	initial begin
		rst_i = 1'b1;
		imem_data_i = 32'h0;
		build_random_program();
		reset_core();
		run_program(1'b0);
		// short second run ending on an illegal word at address 8
		build_illegal_program();
		reset_core();
		run_program(1'b1);
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the core did not halt in the expected time");
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

/* verilog.f */
rtl/rv_pkg.sv
rtl/rv_issue_if.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_branch.sv
rtl/rv_writeback.sv
rtl/rv_core.sv
bench/rv_core_properties.sv
bench/rv_core_tb.sv

/* Makefile */
PASS_MSG := Simulation completed successfully

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module rv_core_tb -f verilog.f

run: compile
	out=$$(./obj_dir/Vrv_core_tb); status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
